//--- src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  // ====================
  // ALU and condition encodings
  // ====================

  // Matches the data-processing opcode field, instr[24:21]
  typedef enum logic [3:0] {
    andOp, eorOp, subOp, rsbOp,
    addOp, adcOp, sbcOp, rscOp,
    tstOp, teqOp, cmpOp, cmnOp,
    orrOp, movOp, bicOp, mvnOp
  } aluOpT;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    eq, ne, cs, cc,
    mi, pl, vs, vc,
    hi, ls, ge, lt,
    gt, le, al, nv  // nv treated as never
  } condT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef logic [1:0] srcSelT;  // Register or immediate source select

  // ====================
  // Decoded control word
  // ====================
  typedef struct packed {
    srcSelT     regSrc;
    srcSelT     immSrc;
    logic       aluSrc;      // 1 = immediate operand B
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic [1:0] flagWrite;   // [1] NZ, [0] CV
    aluOpT      aluControl;
    logic       byteAccess;  // LDRB / STRB
    logic       pcSrc;       // Writes r15 or branches
  } ctrlDecodeT;

endpackage

`default_nettype wire

//--- src/decodeIf.sv
`timescale 1ns/1ns
`default_nettype none

// Decoded controls crossing from D into the E register
interface decodeIf;

  ctrlPkg::ctrlDecodeT ctrl;
  ctrlPkg::condT       cond;

  modport decoder (
    output ctrl,
    output cond
  );

  modport execute (
    input ctrl,
    input cond
  );

endinterface

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
  input  logic [31:0] instrD,
  decodeIf.decoder    dec
);

  ctrlPkg::ctrlDecodeT ctrlD;
  logic [1:0]          op;         // Instruction class
  logic                immForm;    // I bit
  logic                sBit;       // S bit, or L bit for memory ops
  logic                upBit;      // U bit, offset direction
  logic                isCompare;  // tst teq cmp cmn
  logic                extraSpace; // Multiply and halfword encodings

  assign op         = instrD[27:26];
  assign immForm    = instrD[25];
  assign sBit       = instrD[20];
  assign upBit      = instrD[23];
  assign isCompare  = instrD[24:23] == 2'b10;
  assign extraSpace = ~instrD[25] & instrD[7] & instrD[4];

  // ====================
  // Main decoder
  // ====================
  always_comb begin
    ctrlD = '0;  // Bubble unless a case below fills it in
    case (op)
      2'b00: begin
        // Data processing, compares need S set
        if (!extraSpace && !(isCompare && !sBit)) begin
          ctrlD.aluSrc     = immForm;            // rot imm8 or Rm
          ctrlD.regWrite   = ~isCompare;         // Compares only set flags
          ctrlD.flagWrite  = {sBit, sBit};
          ctrlD.aluControl = ctrlPkg::aluOpT'(instrD[24:21]);
        end
      end
      2'b01: begin
        // Register offset with bit 4 set is undefined
        if (!(immForm && instrD[4])) begin
          ctrlD.regSrc     = sBit ? 2'b00 : 2'b10;  // STR reads Rd as data
          ctrlD.immSrc     = 2'b01;                 // imm12
          ctrlD.aluSrc     = ~immForm;              // I=0 means immediate offset
          ctrlD.memtoReg   = sBit;
          ctrlD.regWrite   = sBit;                  // Load
          ctrlD.memWrite   = ~sBit;                 // Store
          ctrlD.byteAccess = instrD[22];
          ctrlD.aluControl = upBit ? ctrlPkg::addOp : ctrlPkg::subOp;
        end
      end
      2'b10: begin
        // B only, block transfers are not decoded here
        if (immForm) begin
          ctrlD.regSrc     = 2'b01;  // PC as Rn
          ctrlD.immSrc     = 2'b10;  // imm24
          ctrlD.aluSrc     = 1'b1;
          ctrlD.branch     = 1'b1;
          ctrlD.aluControl = ctrlPkg::addOp;
        end
      end
      default: ctrlD = '0;  // Coprocessor and SWI space
    endcase

    // PC changes on branch or on a write to r15
    ctrlD.pcSrc = ctrlD.branch | (ctrlD.regWrite & (instrD[15:12] == 4'hF));
  end

  assign dec.ctrl = ctrlD;
  assign dec.cond = ctrlPkg::condT'(instrD[31:28]);

endmodule

`default_nettype wire

//--- src/condUnit.sv
`timescale 1ns/1ns
`default_nettype none

module condUnit (
  input  logic           clk,
  input  logic           rst,
  input  logic           en,        // Low while E is stalled
  input  ctrlPkg::condT  cond,
  input  logic [1:0]     flagWrite, // [1] NZ, [0] CV
  input  ctrlPkg::flagsT aluFlags,
  output logic           condEx,
  output ctrlPkg::flagsT flags
);

  ctrlPkg::flagsT flagsQ;

  // ====================
  // Condition check
  // ====================
  always_comb begin
    case (cond)
      ctrlPkg::eq: condEx = flagsQ.z;
      ctrlPkg::ne: condEx = ~flagsQ.z;
      ctrlPkg::cs: condEx = flagsQ.c;
      ctrlPkg::cc: condEx = ~flagsQ.c;
      ctrlPkg::mi: condEx = flagsQ.n;
      ctrlPkg::pl: condEx = ~flagsQ.n;
      ctrlPkg::vs: condEx = flagsQ.v;
      ctrlPkg::vc: condEx = ~flagsQ.v;
      ctrlPkg::hi: condEx = flagsQ.c & ~flagsQ.z;   // Unsigned higher
      ctrlPkg::ls: condEx = ~flagsQ.c | flagsQ.z;
      ctrlPkg::ge: condEx = flagsQ.n == flagsQ.v;   // Signed
      ctrlPkg::lt: condEx = flagsQ.n != flagsQ.v;
      ctrlPkg::gt: condEx = ~flagsQ.z & (flagsQ.n == flagsQ.v);
      ctrlPkg::le: condEx = flagsQ.z | (flagsQ.n != flagsQ.v);
      ctrlPkg::al: condEx = 1'b1;
      default:     condEx = 1'b0;  // nv
    endcase
  end

  // Flags land at the end of the E cycle, next instruction sees them
  always_ff @(posedge clk) begin
    if (rst) begin
      flagsQ <= '0;
    end else if (en && condEx) begin
      if (flagWrite[1]) begin
        flagsQ.n <= aluFlags.n;
        flagsQ.z <= aluFlags.z;
      end
      if (flagWrite[0]) begin
        flagsQ.c <= aluFlags.c;
        flagsQ.v <= aluFlags.v;
      end
    end
  end

  assign flags = flagsQ;

endmodule

`default_nettype wire

//--- src/executeCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module executeCtrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           stallE,
  input  logic           flushE,
  decodeIf.execute       dec,
  input  ctrlPkg::flagsT aluFlagsE,
  input  logic [31:0]    aluResultE,  // Memory address for loads and stores
  output logic           aluSrcE,
  output ctrlPkg::aluOpT aluControlE,
  output logic           branchTakenE,
  output ctrlPkg::flagsT flagsE,
  output logic           pcSrcE,      // Ungated, for the pending check
  output logic           memWriteGated,
  output logic           regWriteGated,
  output logic           memtoReg,
  output logic           pcSrcGated,
  output logic [3:0]     byteMask
);

  ctrlPkg::ctrlDecodeT ctrlE;
  ctrlPkg::condT       condE;
  logic                condExE;

  // ====================
  // E pipeline register
  // ====================
  always_ff @(posedge clk) begin
    if (rst || flushE) begin   // Flush wins over stall
      ctrlE <= '0;
      condE <= ctrlPkg::eq;
    end else if (!stallE) begin
      ctrlE <= dec.ctrl;
      condE <= dec.cond;
    end
  end

  condUnit condCheck (
    .clk       (clk),
    .rst       (rst),
    .en        (~stallE),
    .cond      (condE),
    .flagWrite (ctrlE.flagWrite),
    .aluFlags  (aluFlagsE),
    .condEx    (condExE),
    .flags     (flagsE)
  );

  assign aluSrcE     = ctrlE.aluSrc;
  assign aluControlE = ctrlE.aluControl;
  assign pcSrcE      = ctrlE.pcSrc;

  // Failed condition kills every side effect
  assign branchTakenE  = ctrlE.branch & condExE;
  assign regWriteGated = ctrlE.regWrite & condExE;
  assign memWriteGated = ctrlE.memWrite & condExE;
  assign pcSrcGated    = ctrlE.pcSrc & condExE;
  assign memtoReg      = ctrlE.memtoReg;

  // Byte lane enables, lane 0 is address bits 1:0 == 0
  always_comb begin
    if (ctrlE.byteAccess) begin
      byteMask = 4'b0001 << aluResultE[1:0];
    end else begin
      byteMask = 4'b1111;  // Word access
    end
  end

endmodule

`default_nettype wire

//--- src/memWbCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module memWbCtrl (
  input  logic       clk,
  input  logic       rst,
  input  logic       stallM,
  input  logic       stallW,
  input  logic       flushW,
  input  logic       pcSrcD,
  input  logic       pcSrcE,
  input  logic       memWriteGated,
  input  logic       regWriteGated,
  input  logic       memtoReg,
  input  logic       pcSrcGated,
  input  logic [3:0] byteMask,
  output logic       memWriteM,
  output logic [3:0] byteMaskM,
  output logic       regWriteW,
  output logic       memtoRegW,
  output logic       pcSrcW,
  output logic       pcWrPendingF
);

  logic regWriteM;
  logic memtoRegM;
  logic pcSrcM;

  // ====================
  // M register, no flush
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      memWriteM <= 1'b0;
      byteMaskM <= 4'b0000;
      regWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      pcSrcM    <= 1'b0;
    end else if (!stallM) begin
      memWriteM <= memWriteGated;
      byteMaskM <= byteMask;
      regWriteM <= regWriteGated;
      memtoRegM <= memtoReg;
      pcSrcM    <= pcSrcGated;
    end
  end

  // ====================
  // W register
  // ====================
  always_ff @(posedge clk) begin
    if (rst || flushW) begin
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else if (!stallW) begin
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW    <= pcSrcM;
    end
  end

  // Fetch waits while any PC write is still in flight
  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;

endmodule

`default_nettype wire

//--- src/armController.sv
`timescale 1ns/1ns
`default_nettype none

module armController (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] instrD,
  input  logic [3:0]  aluFlagsE,   // NZCV from the ALU
  input  logic [31:0] aluResultE,
  input  logic        stallE,
  input  logic        flushE,
  input  logic        stallM,
  input  logic        stallW,
  input  logic        flushW,
  output logic [1:0]  regSrcD,
  output logic [1:0]  immSrcD,
  output logic        aluSrcE,
  output logic [3:0]  aluControlE,
  output logic        branchTakenE,
  output logic [3:0]  flagsE,
  output logic        memWriteM,
  output logic [3:0]  byteMaskM,
  output logic        regWriteW,
  output logic        memtoRegW,
  output logic        pcSrcW,
  output logic        pcWrPendingF
);

  decodeIf decBus ();

  logic       pcSrcE;
  logic       memWriteGated;
  logic       regWriteGated;
  logic       memtoReg;
  logic       pcSrcGated;
  logic [3:0] byteMask;

  // ====================
  // Decode
  // ====================
  instrDecoder decoder (
    .instrD (instrD),
    .dec    (decBus.decoder)
  );

  assign regSrcD = decBus.ctrl.regSrc;
  assign immSrcD = decBus.ctrl.immSrc;

  // ====================
  // Execute
  // ====================
  executeCtrl exCtrl (
    .clk           (clk),
    .rst           (rst),
    .stallE        (stallE),
    .flushE        (flushE),
    .dec           (decBus.execute),
    .aluFlagsE     (ctrlPkg::flagsT'(aluFlagsE)),
    .aluResultE    (aluResultE),
    .aluSrcE       (aluSrcE),
    .aluControlE   (aluControlE),
    .branchTakenE  (branchTakenE),
    .flagsE        (flagsE),
    .pcSrcE        (pcSrcE),
    .memWriteGated (memWriteGated),
    .regWriteGated (regWriteGated),
    .memtoReg      (memtoReg),
    .pcSrcGated    (pcSrcGated),
    .byteMask      (byteMask)
  );

  // ====================
  // Memory and writeback
  // ====================
  memWbCtrl mwCtrl (
    .clk           (clk),
    .rst           (rst),
    .stallM        (stallM),
    .stallW        (stallW),
    .flushW        (flushW),
    .pcSrcD        (decBus.ctrl.pcSrc),
    .pcSrcE        (pcSrcE),
    .memWriteGated (memWriteGated),
    .regWriteGated (regWriteGated),
    .memtoReg      (memtoReg),
    .pcSrcGated    (pcSrcGated),
    .byteMask      (byteMask),
    .memWriteM     (memWriteM),
    .byteMaskM     (byteMaskM),
    .regWriteW     (regWriteW),
    .memtoRegW     (memtoRegW),
    .pcSrcW        (pcSrcW),
    .pcWrPendingF  (pcWrPendingF)
  );

endmodule

`default_nettype wire

//--- bench/armController_assert.sv
`timescale 1ns/1ns
`default_nettype none

module armController_assert (
  input logic        clk,
  input logic        rst,
  input logic        stallE,
  input logic        flushE,
  input logic        stallM,
  input logic [31:0] aluResultE,
  input logic        pcSrcD,
  input logic        memWriteGated,
  input logic        memWriteM,
  input logic [3:0]  byteMaskM,
  input logic        regWriteW,
  input logic        pcSrcW,
  input logic        branchTakenE,
  input logic        pcWrPendingF
);

  // Pipeline empty right after reset
  resetQuiet: assert property (@(posedge clk)
    rst |=> !(memWriteM | regWriteW | pcSrcW | branchTakenE))
    else $error("write control active in the cycle after reset");

  // A PC write that moves from D into E keeps fetch waiting
  pendingInE: assert property (@(posedge clk) disable iff (rst)
    (pcSrcD && !stallE && !flushE) |=> pcWrPendingF)
    else $error("pcWrPendingF low while a PC write sits in E");

  // Store enables the byte lane its address points at
  storeHasLanes: assert property (@(posedge clk) disable iff (rst)
    (memWriteGated && !stallM) |=> (memWriteM && byteMaskM[$past(aluResultE[1:0])]))
    else $error("memory write without the addressed byte lane");

endmodule

bind armController armController_assert pipeChecks (
  .clk           (clk),
  .rst           (rst),
  .stallE        (stallE),
  .flushE        (flushE),
  .stallM        (stallM),
  .aluResultE    (aluResultE),
  .pcSrcD        (decBus.ctrl.pcSrc),
  .memWriteGated (memWriteGated),
  .memWriteM     (memWriteM),
  .byteMaskM     (byteMaskM),
  .regWriteW     (regWriteW),
  .pcSrcW        (pcSrcW),
  .branchTakenE  (branchTakenE),
  .pcWrPendingF  (pcWrPendingF)
);

`default_nettype wire

//--- bench/armController_tb.sv
`timescale 1ns/1ns
`default_nettype none

module armController_tb;

  localparam int          caseWords   = 15;            // Tokens per case line
  localparam int          maxCases    = 16;            // Including the end marker
  localparam logic [31:0] bubbleInstr = 32'h0C00_0000; // Coprocessor space decodes to nothing

  logic        clk;
  logic        rst;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [31:0] aluResultE;
  logic        stallE;
  logic        flushE;
  logic        stallM;
  logic        stallW;
  logic        flushW;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  logic [3:0]  aluControlE;
  logic        branchTakenE;
  logic [3:0]  flagsE;
  logic        memWriteM;
  logic [3:0]  byteMaskM;
  logic        regWriteW;
  logic        memtoRegW;
  logic        pcSrcW;
  logic        pcWrPendingF;

  logic [31:0] caseMem [0:caseWords*maxCases-1];
  logic [31:0] lcgState;
  logic [7:0]  caseName;  // Code of the case now running

  armController armController_inst (
    .clk (clk), .rst (rst), .instrD (instrD), .aluFlagsE (aluFlagsE),
    .aluResultE (aluResultE), .stallE (stallE), .flushE (flushE), .stallM (stallM),
    .stallW (stallW), .flushW (flushW), .regSrcD (regSrcD), .immSrcD (immSrcD),
    .aluSrcE (aluSrcE), .aluControlE (aluControlE), .branchTakenE (branchTakenE),
    .flagsE (flagsE), .memWriteM (memWriteM), .byteMaskM (byteMaskM),
    .regWriteW (regWriteW), .memtoRegW (memtoRegW), .pcSrcW (pcSrcW),
    .pcWrPendingF (pcWrPendingF)
  );

  always #10 clk = ~clk;  // 20 ns period

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Operand selects by instruction class as {regSrc, immSrc, aluSrc}
  function automatic logic [4:0] expectedSelects(input logic [31:0] instr);
    logic [4:0] sel;
    sel = 5'b0;
    case (instr[27:26])
      2'b00: sel = {2'b00, 2'b00, instr[25]};                     // Rotated imm8 or Rm
      2'b01: sel = {(instr[20] ? 2'b00 : 2'b10), 2'b01, ~instr[25]}; // STR reads Rd
      2'b10: begin
        if (instr[25]) begin
          sel = {2'b01, 2'b10, 1'b1};  // PC plus imm24
        end
      end
      default: sel = 5'b0;
    endcase
    return sel;
  endfunction

  task automatic nextDrive();
    @(posedge clk);
    #2;  // Inputs change just after the edge
  endtask

  task automatic stopRun();
    $display("** FAIL **");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic checkCtrl(input string what, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("ERR %s case %02h expected %b actual %b", what, caseName, expVal, actVal);
      stopRun();
    end
  endtask

  task automatic checkSel(input string what, input ctrlPkg::srcSelT expVal,
                          input ctrlPkg::srcSelT actVal);
    if (actVal !== expVal) begin
      $display("ERR %s case %02h expected %b actual %b", what, caseName, expVal, actVal);
      stopRun();
    end
  endtask

  task automatic checkAluOp(input string what, input ctrlPkg::aluOpT expVal,
                            input ctrlPkg::aluOpT actVal);
    if (actVal !== expVal) begin
      $display("ERR %s case %02h expected %s actual %s", what, caseName,
               expVal.name(), actVal.name());
      stopRun();
    end
  endtask

  task automatic checkFlags(input string what, input ctrlPkg::flagsT expVal,
                            input ctrlPkg::flagsT actVal);
    if (actVal !== expVal) begin
      $display("ERR %s case %02h expected %b actual %b", what, caseName, expVal, actVal);
      stopRun();
    end
  endtask

  task automatic checkMask(input string what, input logic [3:0] expVal,
                           input logic [3:0] actVal);
    if (actVal !== expVal) begin
      $display("ERR %s case %02h expected %b actual %b", what, caseName, expVal, actVal);
      stopRun();
    end
  endtask

  // Fetch may only go on once no PC write is in flight
  task automatic waitPendingClear();
    int cycles;
    cycles = 0;
    while (pcWrPendingF !== 1'b0) begin
      if (cycles == 8) begin
        $display("pcWrPendingF never dropped after case %02h", caseName);
        stopRun();
      end else begin
        nextDrive();
        cycles++;
      end
    end
  endtask

  // ====================
  // One instruction through D, E, M and W
  // ====================
  task automatic runCase(input int idx);
    int          base;
    logic [31:0] fill;
    logic [3:0]  mode;      // Bit 0 stalls E once and bit 1 flushes E
    logic [3:0]  expAluOp;
    logic [3:0]  expFlags;
    logic [3:0]  expMask;
    logic [4:0]  expSel;
    logic        expBranch;
    logic        expMemWrite;
    logic        expRegWrite;
    logic        expMemtoReg;
    logic        expPcSrc;
    logic        expPending;
    base        = idx * caseWords;
    caseName    = caseMem[base][7:0];
    fill        = caseMem[base + 2];
    mode        = caseMem[base + 5][3:0];
    expAluOp    = caseMem[base + 6][3:0];
    expFlags    = caseMem[base + 7][3:0];
    expBranch   = caseMem[base + 8][0];
    expMemWrite = caseMem[base + 9][0];
    expMask     = caseMem[base + 10][3:0];
    expRegWrite = caseMem[base + 11][0];
    expMemtoReg = caseMem[base + 12][0];
    expPcSrc    = caseMem[base + 13][0];
    expPending  = caseMem[base + 14][0];
    expSel      = expectedSelects(caseMem[base + 1]);

    nextDrive();
    instrD     = (caseMem[base + 1] & ~fill) | (lcgNext() & fill);  // Random don't-care bits
    aluFlagsE  = caseMem[base + 3][3:0];
    aluResultE = (lcgNext() & 32'hFFFF_FFFC) | (caseMem[base + 4] & 32'h0000_0003);
    flushE     = mode[1];
    #6;
    checkCtrl("pendingD", expPending, pcWrPendingF);
    checkSel("regSrcD", expSel[4:3], regSrcD);
    checkSel("immSrcD", expSel[2:1], immSrcD);

    nextDrive();  // Now in E
    instrD = bubbleInstr;
    flushE = 1'b0;
    stallE = mode[0];
    #6;
    checkAluOp("aluControlE", ctrlPkg::aluOpT'(expAluOp), ctrlPkg::aluOpT'(aluControlE));
    checkCtrl("aluSrcE", expSel[0] & ~mode[1], aluSrcE);  // Flushed bubble has none
    checkCtrl("branchTakenE", expBranch, branchTakenE);
    checkCtrl("pendingE", expPending, pcWrPendingF);
    if (mode[0]) begin
      nextDrive();  // E held for one cycle
      stallE = 1'b0;
      #6;
      checkAluOp("aluControlHeld", ctrlPkg::aluOpT'(expAluOp), ctrlPkg::aluOpT'(aluControlE));
    end

    nextDrive();  // M stage with flags written at the edge that ended E
    #6;
    checkFlags("flagsE", ctrlPkg::flagsT'(expFlags), ctrlPkg::flagsT'(flagsE));
    checkCtrl("memWriteM", expMemWrite, memWriteM);
    checkMask("byteMaskM", expMask, byteMaskM);
    checkCtrl("pendingM", expPcSrc, pcWrPendingF);  // Gated copy in M

    nextDrive();  // W
    #6;
    checkCtrl("regWriteW", expRegWrite, regWriteW);
    checkCtrl("memtoRegW", expMemtoReg, memtoRegW);
    checkCtrl("pcSrcW", expPcSrc, pcSrcW);
    waitPendingClear();
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    int idx;
    clk        = 1'b0;
    rst        = 1'b1;
    instrD     = bubbleInstr;
    aluFlagsE  = 4'h0;
    aluResultE = 32'h0;
    stallE     = 1'b0;
    flushE     = 1'b0;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushW     = 1'b0;
    lcgState   = 32'd25;
    caseName   = 8'h00;
    for (idx = 0; idx < caseWords * maxCases; idx++) begin
      caseMem[idx] = '0;
    end
    $readmemh("bench/controller_cases.txt", caseMem);
    if (caseMem[0][7:0] == 8'h00) begin
      $display("case file bench/controller_cases.txt is missing or empty");
      stopRun();
    end

    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    #6;
    checkCtrl("resetMemWriteM", 1'b0, memWriteM);
    checkCtrl("resetRegWriteW", 1'b0, regWriteW);
    checkCtrl("resetPcSrcW", 1'b0, pcSrcW);
    checkCtrl("resetBranchTakenE", 1'b0, branchTakenE);
    checkFlags("resetFlagsE", '0, ctrlPkg::flagsT'(flagsE));

    idx = 0;
    while (idx < maxCases && caseMem[idx * caseWords][7:0] != 8'hFF) begin
      runCase(idx);
      idx++;
    end

    if (idx == maxCases) begin
      $display("case file has no end marker line");
      stopRun();
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/controller_cases.txt
// name instr fill nzcv addr mode then expected aluOp nzcv branch memWrite mask regWrite
// memtoReg pcSrc pending. Mode bit 0 stalls E once and bit 1 flushes E. Name ff ends the list
01 e0812003 000f000f 0 00000000 0  4 0 0 0 f 1 0 0 0
02 e1510001 000f000f 6 00000000 0  a 6 0 0 f 0 0 0 0
03 00812003 000f000f 0 00000000 0  4 6 0 0 f 1 0 0 0
04 e2512001 000f0fff 8 00000000 0  2 8 0 0 f 1 0 0 0
05 b0812003 000f000f 0 00000000 0  4 8 0 0 f 1 0 0 0
06 a0812003 000f000f 0 00000000 0  4 8 0 0 f 0 0 0 0
07 ea000010 00ffffff 0 00000000 0  4 8 1 0 f 0 0 1 1
08 0a000010 00ffffff 0 00000000 0  4 8 0 0 f 0 0 0 1
09 e5812004 000f0fff 0 00000001 0  4 8 0 1 f 0 0 0 0
0a e5c12004 000f0fff 0 00000002 0  4 8 0 1 4 0 0 0 0
0b e5412004 000f0fff 0 00000003 0  2 8 0 1 8 0 0 0 0
0c e5912004 000f0fff 0 00000000 0  4 8 0 0 f 1 1 0 0
0d e0812003 000f000f 0 00000000 1  4 8 0 0 f 1 0 0 0
0e e0812003 000f000f 0 00000000 2  0 8 0 0 f 0 0 0 0
0f e1a0f001 000f000f 0 00000000 0  d 8 0 0 f 1 0 1 1
ff 00000000 00000000 0 00000000 0  0 0 0 0 0 0 0 0 0

//--- files.f
src/ctrlPkg.sv
src/decodeIf.sv
src/instrDecoder.sv
src/condUnit.sv
src/executeCtrl.sv
src/memWbCtrl.sv
src/armController.sv
bench/armController_assert.sv
bench/armController_tb.sv

//--- run.sh
#!/bin/sh
# Build the controller testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module armController_tb -f files.f -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -qF "** FAIL **" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi
exit 0
